/* hdl/mm_config.svh */
`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

// one machine word, used for data and for addresses
`define MM_DATA_W 32

// register number field in the command word
`define MM_REG_NUM_W 4

// register that holds the instruction pointer
`define MM_REG_IP 15

`endif

/* hdl/seq_state_pkg.sv */
`default_nettype none

package seq_state_pkg;

  // states presented by the external sequencer
  typedef enum logic [4:0] {
    IDLE,
    START_READ_CMD,
    START_READ_CMD_P,
    READ_COND,
    READ_COND_P,
    READ_SRC1,
    READ_SRC1_P,
    FILL_SRC1,
    READ_SRC0,
    READ_SRC0_P,
    FILL_SRC0,
    READ_DST,
    ALU_RESULTS,
    WRITE_PREP,
    WRITE_REG_IP,
    WRITE_DST,
    WRITE_DST_P
  } seq_state_t;

  // one-cycle operation handed to a register slot
  typedef enum logic [2:0] {
    OP_NULL,
    OP_READ,
    OP_READ_P,
    OP_CATCH,
    OP_WRITE_PREP,
    OP_WRITE,
    OP_WRITE_P
  } reg_op_t;

endpackage

`default_nettype wire

/* hdl/cmd_word_pkg.sv */
`default_nettype none

`include "mm_config.svh"

package cmd_word_pkg;

  // post-modify flag per operand field
  // keep behaves like none
  typedef enum logic [1:0] {
    MOD_NONE = 2'b00,
    MOD_INC  = 2'b01,
    MOD_DEC  = 2'b10,
    MOD_KEEP = 2'b11
  } mod_flag_t;

  // top nibble of the command word, only the ALU looks at it
  typedef enum logic [3:0] {
    CMD_NOP  = 4'h0,
    CMD_MOV  = 4'h1,
    CMD_ADD  = 4'h2,
    CMD_SUB  = 4'h3,
    CMD_AND  = 4'h4,
    CMD_OR   = 4'h5,
    CMD_XOR  = 4'h6,
    CMD_SHL  = 4'h7,
    CMD_SHR  = 4'h8,
    CMD_CALL = 4'hd,
    CMD_HLT  = 4'hf
  } cmd_code_t;

  typedef logic [`MM_REG_NUM_W-1:0] reg_num_t;

endpackage

`default_nettype wire

/* hdl/cmd_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mm_config.svh"

module cmd_decode (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire seq_state_pkg::seq_state_t state,
  input  wire logic [`MM_DATA_W-1:0]   command_word,
  output cmd_word_pkg::reg_num_t       cond_num,
  output cmd_word_pkg::reg_num_t       src1_num,
  output cmd_word_pkg::reg_num_t       src0_num,
  output cmd_word_pkg::reg_num_t       dst_num,
  output logic                         cond_ptr,
  output logic                         src1_ptr,
  output logic                         src0_ptr,
  output logic                         dst_ptr,
  output cmd_word_pkg::mod_flag_t      cond_mod,
  output cmd_word_pkg::mod_flag_t      src1_mod,
  output cmd_word_pkg::mod_flag_t      src0_mod,
  output cmd_word_pkg::mod_flag_t      dst_mod,
  output seq_state_pkg::reg_op_t       ip_op,
  output seq_state_pkg::reg_op_t       cond_op,
  output seq_state_pkg::reg_op_t       src1_op,
  output seq_state_pkg::reg_op_t       src0_op,
  output seq_state_pkg::reg_op_t       dst_op
);

  seq_state_pkg::seq_state_t prev_state;

  // register numbers, low nibbles
  assign src1_num = command_word[3:0];
  assign src0_num = command_word[7:4];
  assign dst_num  = command_word[11:8];
  assign cond_num = command_word[15:12];

  // pointer bits, same field order
  assign src1_ptr = command_word[16];
  assign src0_ptr = command_word[17];
  assign dst_ptr  = command_word[18];
  assign cond_ptr = command_word[19];

  // two flag bits per field
  assign src1_mod = cmd_word_pkg::mod_flag_t'(command_word[21:20]);
  assign src0_mod = cmd_word_pkg::mod_flag_t'(command_word[23:22]);
  assign dst_mod  = cmd_word_pkg::mod_flag_t'(command_word[25:24]);
  assign cond_mod = cmd_word_pkg::mod_flag_t'(command_word[27:26]);

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_state <= seq_state_pkg::IDLE;
      ip_op      <= seq_state_pkg::OP_NULL;
      cond_op    <= seq_state_pkg::OP_NULL;
      src1_op    <= seq_state_pkg::OP_NULL;
      src0_op    <= seq_state_pkg::OP_NULL;
      dst_op     <= seq_state_pkg::OP_NULL;
    end else begin
      prev_state <= state;
      // ops last one cycle only
      ip_op      <= seq_state_pkg::OP_NULL;
      cond_op    <= seq_state_pkg::OP_NULL;
      src1_op    <= seq_state_pkg::OP_NULL;
      src0_op    <= seq_state_pkg::OP_NULL;
      dst_op     <= seq_state_pkg::OP_NULL;
      // issue only on entry into a state, idle falls to default
      if (state != prev_state) begin
        case (state)
          seq_state_pkg::START_READ_CMD:   ip_op   <= seq_state_pkg::OP_READ;
          seq_state_pkg::START_READ_CMD_P: ip_op   <= seq_state_pkg::OP_READ_P;
          seq_state_pkg::READ_COND:        cond_op <= seq_state_pkg::OP_READ;
          seq_state_pkg::READ_COND_P:      cond_op <= seq_state_pkg::OP_READ_P;
          seq_state_pkg::READ_SRC1:        src1_op <= seq_state_pkg::OP_READ;
          seq_state_pkg::READ_SRC1_P:      src1_op <= seq_state_pkg::OP_READ_P;
          seq_state_pkg::FILL_SRC1:        src1_op <= seq_state_pkg::OP_CATCH;
          seq_state_pkg::READ_SRC0:        src0_op <= seq_state_pkg::OP_READ;
          seq_state_pkg::READ_SRC0_P:      src0_op <= seq_state_pkg::OP_READ_P;
          seq_state_pkg::FILL_SRC0:        src0_op <= seq_state_pkg::OP_CATCH;
          seq_state_pkg::READ_DST:         dst_op  <= seq_state_pkg::OP_READ;
          seq_state_pkg::ALU_RESULTS:      dst_op  <= seq_state_pkg::OP_CATCH;
          seq_state_pkg::WRITE_PREP: begin
            // every slot post-modifies at once
            ip_op   <= seq_state_pkg::OP_WRITE_PREP;
            cond_op <= seq_state_pkg::OP_WRITE_PREP;
            src1_op <= seq_state_pkg::OP_WRITE_PREP;
            src0_op <= seq_state_pkg::OP_WRITE_PREP;
            dst_op  <= seq_state_pkg::OP_WRITE_PREP;
          end
          seq_state_pkg::WRITE_REG_IP:     ip_op   <= seq_state_pkg::OP_WRITE;
          seq_state_pkg::WRITE_DST:        dst_op  <= seq_state_pkg::OP_WRITE;
          seq_state_pkg::WRITE_DST_P:      dst_op  <= seq_state_pkg::OP_WRITE_P;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ip_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mm_config.svh"

module ip_fetch (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire seq_state_pkg::reg_op_t op,
  input  wire logic [`MM_DATA_W-1:0] base_addr,
  input  wire logic [`MM_DATA_W-1:0] base_addr_data,
  input  wire logic [`MM_DATA_W-1:0] data_in,
  input  wire logic                  read_dn,
  input  wire logic                  write_dn,
  output logic [`MM_DATA_W-1:0]      addr_out,
  output logic [`MM_DATA_W-1:0]      data_out,
  output logic                       read_q,
  output logic                       write_q,
  output logic                       done,
  output logic [`MM_DATA_W-1:0]      ip,
  output logic [`MM_DATA_W-1:0]      command_word
);

  logic [`MM_DATA_W-1:0] ip_reg_addr;
  logic [`MM_DATA_W-1:0] addr_r;
  logic [`MM_DATA_W-1:0] data_r;
  // open read targets the command word, else the ip
  logic                  fetch_cmd;

  assign ip_reg_addr = base_addr_data + `MM_DATA_W'(`MM_REG_IP);

  // idle slot keeps the shared bus at zero
  assign addr_out = (read_q | write_q) ? addr_r : '0;
  assign data_out = write_q ? data_r : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      ip           <= '0;
      command_word <= '0;
      read_q       <= 1'b0;
      write_q      <= 1'b0;
      done         <= 1'b0;
      fetch_cmd    <= 1'b0;
    end else begin
      done <= 1'b0;
      // bus completion, drop request and report
      if (read_q && read_dn) begin
        read_q <= 1'b0;
        done   <= 1'b1;
        if (fetch_cmd) begin
          command_word <= data_in;
        end else begin
          ip <= data_in;
        end
      end
      if (write_q && write_dn) begin
        write_q <= 1'b0;
        done    <= 1'b1;
      end
      case (op)
        seq_state_pkg::OP_READ: begin
          read_q    <= 1'b1;
          fetch_cmd <= 1'b0;
        end
        seq_state_pkg::OP_READ_P: begin
          read_q    <= 1'b1;
          fetch_cmd <= 1'b1;
        end
        // post-increment, no bus
        seq_state_pkg::OP_WRITE_PREP: begin
          ip   <= ip + 1'b1;
          done <= 1'b1;
        end
        seq_state_pkg::OP_WRITE: write_q <= 1'b1;
        default: ;
      endcase
    end
  end

  // bus address and data latched with the request
  always_ff @(posedge clk) begin
    case (op)
      seq_state_pkg::OP_READ:   addr_r <= ip_reg_addr;
      seq_state_pkg::OP_READ_P: addr_r <= base_addr + ip;
      seq_state_pkg::OP_WRITE: begin
        addr_r <= ip_reg_addr;
        data_r <= ip;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/reg_slot.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mm_config.svh"

module reg_slot (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire seq_state_pkg::reg_op_t  op,
  input  wire cmd_word_pkg::reg_num_t  reg_num,
  input  wire logic                    is_ptr,
  input  wire cmd_word_pkg::mod_flag_t mod,
  input  wire logic [`MM_DATA_W-1:0]   base_addr,
  input  wire logic [`MM_DATA_W-1:0]   base_addr_data,
  input  wire logic [`MM_DATA_W-1:0]   fwd_value,
  input  wire logic [`MM_DATA_W-1:0]   fwd_ptr,
  input  wire logic                    fwd_has_ptr,
  input  wire logic [`MM_DATA_W-1:0]   data_in,
  input  wire logic                    read_dn,
  input  wire logic                    write_dn,
  output logic [`MM_DATA_W-1:0]        addr_out,
  output logic [`MM_DATA_W-1:0]        data_out,
  output logic                         read_q,
  output logic                         write_q,
  output logic                         done,
  output logic [`MM_DATA_W-1:0]        value,
  output logic [`MM_DATA_W-1:0]        ptr
);

  logic [`MM_DATA_W-1:0] reg_addr;
  logic [`MM_DATA_W-1:0] ptr_base;
  logic [`MM_DATA_W-1:0] step;
  logic [`MM_DATA_W-1:0] addr_r;
  logic [`MM_DATA_W-1:0] data_r;
  // direct read fills the pointer too
  logic                  load_ptr;

  // register n sits at data base plus n
  assign reg_addr = base_addr_data + `MM_DATA_W'(reg_num);

  // ip-relative pointers index program space
  assign ptr_base = (reg_num == `MM_REG_NUM_W'(`MM_REG_IP)) ? base_addr : base_addr_data;

  // +1, -1 or nothing; keep counts as nothing
  assign step = (mod == cmd_word_pkg::MOD_INC) ? `MM_DATA_W'(1) :
                (mod == cmd_word_pkg::MOD_DEC) ? '1 : '0;

  assign addr_out = (read_q | write_q) ? addr_r : '0;
  assign data_out = write_q ? data_r : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      value    <= '0;
      ptr      <= '0;
      read_q   <= 1'b0;
      write_q  <= 1'b0;
      done     <= 1'b0;
      load_ptr <= 1'b0;
    end else begin
      done <= 1'b0;
      if (read_q && read_dn) begin
        read_q <= 1'b0;
        done   <= 1'b1;
        value  <= data_in;
        if (load_ptr) begin
          ptr <= data_in;
        end
      end
      if (write_q && write_dn) begin
        write_q <= 1'b0;
        done    <= 1'b1;
      end
      case (op)
        seq_state_pkg::OP_READ: begin
          read_q   <= 1'b1;
          load_ptr <= 1'b1;
        end
        // indirect read, plain operand just acknowledges
        seq_state_pkg::OP_READ_P: begin
          if (is_ptr) begin
            read_q   <= 1'b1;
            load_ptr <= 1'b0;
          end else begin
            done <= 1'b1;
          end
        end
        seq_state_pkg::OP_CATCH: begin
          value <= fwd_value;
          if (fwd_has_ptr) begin
            ptr <= fwd_ptr;
          end
          done <= 1'b1;
        end
        // post-modify hits the pointer of an indirect operand
        seq_state_pkg::OP_WRITE_PREP: begin
          if (is_ptr) begin
            ptr <= ptr + step;
          end else begin
            value <= value + step;
          end
          done <= 1'b1;
        end
        seq_state_pkg::OP_WRITE:   write_q <= 1'b1;
        seq_state_pkg::OP_WRITE_P: write_q <= 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (op)
      seq_state_pkg::OP_READ:   addr_r <= reg_addr;
      seq_state_pkg::OP_READ_P: addr_r <= ptr_base + ptr;
      // indirect operand stores its updated pointer
      seq_state_pkg::OP_WRITE: begin
        addr_r <= reg_addr;
        data_r <= is_ptr ? ptr : value;
      end
      seq_state_pkg::OP_WRITE_P: begin
        addr_r <= base_addr_data + ptr;
        data_r <= value;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/operand_forward.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mm_config.svh"

module operand_forward (
  input  wire cmd_word_pkg::reg_num_t  src1_num,
  input  wire cmd_word_pkg::reg_num_t  src0_num,
  input  wire cmd_word_pkg::reg_num_t  cond_num,
  input  wire logic [`MM_DATA_W-1:0]   ip,
  input  wire logic [`MM_DATA_W-1:0]   cond_value,
  input  wire logic [`MM_DATA_W-1:0]   cond_ptr_value,
  input  wire logic [`MM_DATA_W-1:0]   src1_value,
  input  wire logic [`MM_DATA_W-1:0]   src1_ptr_value,
  input  wire logic [`MM_DATA_W-1:0]   src0_value,
  input  wire logic [`MM_DATA_W-1:0]   src0_ptr_value,
  input  wire logic [`MM_DATA_W-1:0]   dst_in,
  output logic [`MM_DATA_W-1:0]        src1_fwd_value,
  output logic [`MM_DATA_W-1:0]        src1_fwd_ptr,
  output logic                         src1_fwd_has_ptr,
  output logic [`MM_DATA_W-1:0]        src0_fwd_value,
  output logic [`MM_DATA_W-1:0]        src0_fwd_ptr,
  output logic                         src0_fwd_has_ptr,
  output logic [`MM_DATA_W-1:0]        dst_fwd_value,
  output logic [`MM_DATA_W-1:0]        dst_fwd_ptr,
  output logic                         dst_fwd_has_ptr
);

  localparam cmd_word_pkg::reg_num_t REG_IP = `MM_REG_NUM_W'(`MM_REG_IP);

  // source 1: ip first, then condition, else own value back
  always_comb begin
    src1_fwd_has_ptr = 1'b1;
    if (src1_num == REG_IP) begin
      src1_fwd_value = ip;
      src1_fwd_ptr   = ip;
    end else if (src1_num == cond_num) begin
      src1_fwd_value = cond_value;
      src1_fwd_ptr   = cond_ptr_value;
    end else begin
      src1_fwd_value   = src1_value;
      src1_fwd_ptr     = src1_ptr_value;
      src1_fwd_has_ptr = 1'b0;
    end
  end

  // source 0 also sees source 1
  always_comb begin
    src0_fwd_has_ptr = 1'b1;
    if (src0_num == REG_IP) begin
      src0_fwd_value = ip;
      src0_fwd_ptr   = ip;
    end else if (src0_num == cond_num) begin
      src0_fwd_value = cond_value;
      src0_fwd_ptr   = cond_ptr_value;
    end else if (src0_num == src1_num) begin
      src0_fwd_value = src1_value;
      src0_fwd_ptr   = src1_ptr_value;
    end else begin
      src0_fwd_value   = src0_value;
      src0_fwd_ptr     = src0_ptr_value;
      src0_fwd_has_ptr = 1'b0;
    end
  end

  // destination takes the ALU result, pointer untouched
  assign dst_fwd_value   = dst_in;
  assign dst_fwd_ptr     = '0;
  assign dst_fwd_has_ptr = 1'b0;

endmodule

`default_nettype wire

/* hdl/mem_manager.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mm_config.svh"

module mem_manager (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire seq_state_pkg::seq_state_t state,
  input  wire logic [`MM_DATA_W-1:0]     base_addr,
  input  wire logic [`MM_DATA_W-1:0]     base_addr_data,
  input  wire logic [`MM_DATA_W-1:0]     data_in,
  input  wire logic                      read_dn,
  input  wire logic                      write_dn,
  input  wire logic [`MM_DATA_W-1:0]     dst_in,
  output logic [`MM_DATA_W-1:0]          addr_out,
  output logic [`MM_DATA_W-1:0]          data_out,
  output logic                           read_q,
  output logic                           write_q,
  output logic                           next_state,
  output logic [`MM_DATA_W-1:0]          command_word,
  output logic [`MM_DATA_W-1:0]          cond_out,
  output logic [`MM_DATA_W-1:0]          src1_out,
  output logic [`MM_DATA_W-1:0]          src0_out,
  output logic [`MM_DATA_W-1:0]          dst_out
);

  // merged bus slots in order ip, cond, src1, src0, dst
  localparam int N = 5;

  cmd_word_pkg::reg_num_t  cond_num, src1_num, src0_num, dst_num;
  logic                    cond_ptr, src1_ptr, src0_ptr, dst_ptr;
  cmd_word_pkg::mod_flag_t cond_mod, src1_mod, src0_mod, dst_mod;
  seq_state_pkg::reg_op_t  ip_op, cond_op, src1_op, src0_op, dst_op;

  logic [`MM_DATA_W-1:0] ip;
  logic [`MM_DATA_W-1:0] cond_ptr_value, src1_ptr_value, src0_ptr_value;
  logic [`MM_DATA_W-1:0] src1_fwd_value, src1_fwd_ptr, src0_fwd_value, src0_fwd_ptr;
  logic [`MM_DATA_W-1:0] dst_fwd_value, dst_fwd_ptr;
  logic                  src1_fwd_has_ptr, src0_fwd_has_ptr, dst_fwd_has_ptr;

  // per-slot bus outputs before the merge
  logic [`MM_DATA_W-1:0] addr_s [N];
  logic [`MM_DATA_W-1:0] data_s [N];
  logic [N-1:0]          read_s, write_s, done_s;

  cmd_decode cmd_decode_inst (
    .clk(clk), .rst(rst), .state(state), .command_word(command_word),
    .cond_num(cond_num), .src1_num(src1_num), .src0_num(src0_num), .dst_num(dst_num),
    .cond_ptr(cond_ptr), .src1_ptr(src1_ptr), .src0_ptr(src0_ptr), .dst_ptr(dst_ptr),
    .cond_mod(cond_mod), .src1_mod(src1_mod), .src0_mod(src0_mod), .dst_mod(dst_mod),
    .ip_op(ip_op), .cond_op(cond_op), .src1_op(src1_op), .src0_op(src0_op),
    .dst_op(dst_op)
  );

  ip_fetch ip_fetch_inst (
    .clk(clk), .rst(rst), .op(ip_op),
    .base_addr(base_addr), .base_addr_data(base_addr_data),
    .data_in(data_in), .read_dn(read_dn), .write_dn(write_dn),
    .addr_out(addr_s[0]), .data_out(data_s[0]),
    .read_q(read_s[0]), .write_q(write_s[0]), .done(done_s[0]),
    .ip(ip), .command_word(command_word)
  );

  operand_forward operand_forward_inst (
    .src1_num(src1_num), .src0_num(src0_num), .cond_num(cond_num), .ip(ip),
    .cond_value(cond_out), .cond_ptr_value(cond_ptr_value),
    .src1_value(src1_out), .src1_ptr_value(src1_ptr_value),
    .src0_value(src0_out), .src0_ptr_value(src0_ptr_value), .dst_in(dst_in),
    .src1_fwd_value(src1_fwd_value), .src1_fwd_ptr(src1_fwd_ptr),
    .src1_fwd_has_ptr(src1_fwd_has_ptr),
    .src0_fwd_value(src0_fwd_value), .src0_fwd_ptr(src0_fwd_ptr),
    .src0_fwd_has_ptr(src0_fwd_has_ptr),
    .dst_fwd_value(dst_fwd_value), .dst_fwd_ptr(dst_fwd_ptr),
    .dst_fwd_has_ptr(dst_fwd_has_ptr)
  );

  // condition never catches so its own value loops back
  reg_slot cond_slot (
    .clk(clk), .rst(rst), .op(cond_op),
    .reg_num(cond_num), .is_ptr(cond_ptr), .mod(cond_mod),
    .base_addr(base_addr), .base_addr_data(base_addr_data),
    .fwd_value(cond_out), .fwd_ptr(cond_ptr_value), .fwd_has_ptr(1'b0),
    .data_in(data_in), .read_dn(read_dn), .write_dn(write_dn),
    .addr_out(addr_s[1]), .data_out(data_s[1]),
    .read_q(read_s[1]), .write_q(write_s[1]), .done(done_s[1]),
    .value(cond_out), .ptr(cond_ptr_value)
  );

  reg_slot src1_slot (
    .clk(clk), .rst(rst), .op(src1_op),
    .reg_num(src1_num), .is_ptr(src1_ptr), .mod(src1_mod),
    .base_addr(base_addr), .base_addr_data(base_addr_data),
    .fwd_value(src1_fwd_value), .fwd_ptr(src1_fwd_ptr), .fwd_has_ptr(src1_fwd_has_ptr),
    .data_in(data_in), .read_dn(read_dn), .write_dn(write_dn),
    .addr_out(addr_s[2]), .data_out(data_s[2]),
    .read_q(read_s[2]), .write_q(write_s[2]), .done(done_s[2]),
    .value(src1_out), .ptr(src1_ptr_value)
  );

  reg_slot src0_slot (
    .clk(clk), .rst(rst), .op(src0_op),
    .reg_num(src0_num), .is_ptr(src0_ptr), .mod(src0_mod),
    .base_addr(base_addr), .base_addr_data(base_addr_data),
    .fwd_value(src0_fwd_value), .fwd_ptr(src0_fwd_ptr), .fwd_has_ptr(src0_fwd_has_ptr),
    .data_in(data_in), .read_dn(read_dn), .write_dn(write_dn),
    .addr_out(addr_s[3]), .data_out(data_s[3]),
    .read_q(read_s[3]), .write_q(write_s[3]), .done(done_s[3]),
    .value(src0_out), .ptr(src0_ptr_value)
  );

  // destination pointer stays inside its slot
  reg_slot dst_slot (
    .clk(clk), .rst(rst), .op(dst_op),
    .reg_num(dst_num), .is_ptr(dst_ptr), .mod(dst_mod),
    .base_addr(base_addr), .base_addr_data(base_addr_data),
    .fwd_value(dst_fwd_value), .fwd_ptr(dst_fwd_ptr), .fwd_has_ptr(dst_fwd_has_ptr),
    .data_in(data_in), .read_dn(read_dn), .write_dn(write_dn),
    .addr_out(addr_s[4]), .data_out(data_s[4]),
    .read_q(read_s[4]), .write_q(write_s[4]), .done(done_s[4]),
    .value(dst_out), .ptr()
  );

  // only one slot active at a time and idle ones drive zero
  always_comb begin
    addr_out = '0;
    data_out = '0;
    for (int i = 0; i < N; i++) begin
      addr_out = addr_out | addr_s[i];
      data_out = data_out | data_s[i];
    end
  end

  assign read_q     = |read_s;
  assign write_q    = |write_s;
  // simultaneous write-prep acks collapse to one pulse
  assign next_state = |done_s;

endmodule

`default_nettype wire

/* verification/mem_manager_model.svh */
`ifndef MEM_MANAGER_MODEL_SVH
`define MEM_MANAGER_MODEL_SVH

// sparse memory, unwritten words follow an address pattern
logic [`MM_DATA_W-1:0] mem [logic [`MM_DATA_W-1:0]];
logic [`MM_DATA_W-1:0] last_rd_addr;
logic [`MM_DATA_W-1:0] last_wr_addr;
logic [`MM_DATA_W-1:0] last_wr_data;
int unsigned           wr_count;

// shadow registers, one value and one pointer per slot
logic [`MM_DATA_W-1:0] exp_ip;
logic [`MM_DATA_W-1:0] exp_cmd;
logic [`MM_DATA_W-1:0] cond_v, cond_p, src1_v, src1_p, src0_v, src0_p, dst_v, dst_p;

function automatic logic [`MM_DATA_W-1:0] mem_word(input logic [`MM_DATA_W-1:0] addr);
  if (mem.exists(addr)) begin
    return mem[addr];
  end
  return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
endfunction

function automatic logic [`MM_DATA_W-1:0] reg_word(input logic [3:0] n);
  return mem_word(base_addr_data + 32'(n));
endfunction

// register 15 points into program space
function automatic logic [`MM_DATA_W-1:0] ptr_word(input logic [3:0] n,
                                                   input logic [`MM_DATA_W-1:0] p);
  if (n == 4'(`MM_REG_IP)) begin
    return mem_word(base_addr + p);
  end
  return mem_word(base_addr_data + p);
endfunction

function automatic logic [`MM_DATA_W-1:0] mod_step(input logic [1:0] mod);
  if (mod == cmd_word_pkg::MOD_INC) begin
    return 32'd1;
  end
  if (mod == cmd_word_pkg::MOD_DEC) begin
    return 32'hffff_ffff;
  end
  return 32'd0;
endfunction

// post-modify moves the pointer of an indirect operand
task automatic prep_slot(input logic is_ptr, input logic [1:0] mod,
                         inout logic [`MM_DATA_W-1:0] v, inout logic [`MM_DATA_W-1:0] p);
  if (is_ptr) begin
    p = p + mod_step(mod);
  end else begin
    v = v + mod_step(mod);
  end
endtask

// answers one request at a time after 0 to 3 wait cycles
task automatic serve_bus();
  int unsigned           delay;
  logic [`MM_DATA_W-1:0] addr;
  logic                  is_read;
  forever begin
    @(posedge clk);
    #1;
    if (read_q === 1'b1 || write_q === 1'b1) begin
      addr    = addr_out;
      is_read = read_q;
      delay   = $urandom_range(3, 0);
      // request must stay up while the done pulse is late
      repeat (delay) begin
        @(posedge clk);
        #1;
        check_value("read_q", 32'(is_read), 32'(read_q));
        check_value("write_q", 32'(!is_read), 32'(write_q));
        check_value("addr_out", addr, addr_out);
      end
      if (is_read) begin
        last_rd_addr = addr;
        data_in      = mem_word(addr);
        read_dn      = 1'b1;
      end else begin
        last_wr_addr = addr;
        last_wr_data = data_out;
        mem[addr]    = data_out;
        wr_count++;
        write_dn     = 1'b1;
      end
      @(posedge clk);
      #1;
      read_dn  = 1'b0;
      write_dn = 1'b0;
      data_in  = '0;
      // request gone right after its done pulse
      check_value("read_q", 32'd0, 32'(read_q));
      check_value("write_q", 32'd0, 32'(write_q));
    end else begin
      // idle bus reads as zero
      check_value("addr_out", 32'd0, addr_out);
      check_value("data_out", 32'd0, data_out);
    end
  end
endtask

`endif

/* verification/mem_manager_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mm_config.svh"

module mem_manager_tb;

  localparam int N_CMDS    = 200;
  localparam int TIMEOUT   = 200;
  localparam int RUN_LIMIT = N_CMDS * 20 * TIMEOUT;

  logic                      clk;
  logic                      rst;
  seq_state_pkg::seq_state_t state;
  logic [`MM_DATA_W-1:0]     base_addr;
  logic [`MM_DATA_W-1:0]     base_addr_data;
  logic [`MM_DATA_W-1:0]     data_in;
  logic                      read_dn;
  logic                      write_dn;
  logic [`MM_DATA_W-1:0]     dst_in;
  logic [`MM_DATA_W-1:0]     addr_out;
  logic [`MM_DATA_W-1:0]     data_out;
  logic                      read_q;
  logic                      write_q;
  logic                      next_state;
  logic [`MM_DATA_W-1:0]     command_word;
  logic [`MM_DATA_W-1:0]     cond_out;
  logic [`MM_DATA_W-1:0]     src1_out;
  logic [`MM_DATA_W-1:0]     src0_out;
  logic [`MM_DATA_W-1:0]     dst_out;

  int unsigned errors;
  logic        hung;
  logic        run_done;

  task automatic check_value(input string name, input logic [`MM_DATA_W-1:0] exp,
                             input logic [`MM_DATA_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  `include "mem_manager_model.svh"

  mem_manager mem_manager_inst (
    .clk(clk), .rst(rst), .state(state),
    .base_addr(base_addr), .base_addr_data(base_addr_data),
    .data_in(data_in), .read_dn(read_dn), .write_dn(write_dn), .dst_in(dst_in),
    .addr_out(addr_out), .data_out(data_out), .read_q(read_q), .write_q(write_q),
    .next_state(next_state), .command_word(command_word),
    .cond_out(cond_out), .src1_out(src1_out), .src0_out(src0_out), .dst_out(dst_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial serve_bus();

  // one cycle past the last pulse, then wait for the slot to finish
  task automatic enter_state(input seq_state_pkg::seq_state_t s);
    int cycles;
    @(posedge clk);
    #1;
    state  = s;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (next_state !== 1'b1 && cycles < TIMEOUT);
    if (next_state !== 1'b1) begin
      errors++;
      $display("Timeout: no next_state pulse after entering %s", s.name());
      hung = 1'b1;
      @(posedge clk);
    end
  endtask

  task automatic run_command();
    logic [`MM_DATA_W-1:0] cmd;
    logic [`MM_DATA_W-1:0] dst_addr;
    logic [3:0]            cn, s1n, s0n, dn;
    logic                  cptr, s1ptr, s0ptr, dptr;
    logic [1:0]            cmod, s1mod, s0mod, dmod;
    int unsigned           wr_before;
    int                    n;
    cmd = $urandom;
    // push fields toward shared numbers and the ip
    if ($urandom_range(3, 0) == 0) cmd[3:0] = cmd[15:12];
    if ($urandom_range(3, 0) == 0) cmd[7:4] = cmd[3:0];
    if ($urandom_range(7, 0) == 0) cmd[7:4] = 4'hf;
    mem[base_addr + exp_ip] = cmd;
    for (n = 0; n < `MM_REG_IP; n++) begin
      mem[base_addr_data + 32'(n)] = $urandom;
    end
    dst_in = $urandom;

    // fetch through register 15
    enter_state(seq_state_pkg::START_READ_CMD);
    check_value("ip read address", base_addr_data + `MM_REG_IP, last_rd_addr);
    enter_state(seq_state_pkg::START_READ_CMD_P);
    check_value("fetch address", base_addr + exp_ip, last_rd_addr);
    exp_cmd = mem_word(base_addr + exp_ip);
    check_value("command_word", exp_cmd, command_word);
    s1n   = exp_cmd[3:0];
    s0n   = exp_cmd[7:4];
    dn    = exp_cmd[11:8];
    cn    = exp_cmd[15:12];
    s1ptr = exp_cmd[16];
    s0ptr = exp_cmd[17];
    dptr  = exp_cmd[18];
    cptr  = exp_cmd[19];
    s1mod = exp_cmd[21:20];
    s0mod = exp_cmd[23:22];
    dmod  = exp_cmd[25:24];
    cmod  = exp_cmd[27:26];

    enter_state(seq_state_pkg::READ_COND);
    cond_v = reg_word(cn);
    cond_p = cond_v;
    check_value("cond_out", cond_v, cond_out);
    if (cptr) begin
      enter_state(seq_state_pkg::READ_COND_P);
      cond_v = ptr_word(cn, cond_p);
      check_value("cond_out", cond_v, cond_out);
    end

    enter_state(seq_state_pkg::READ_SRC1);
    src1_v = reg_word(s1n);
    src1_p = src1_v;
    check_value("src1_out", src1_v, src1_out);
    if (s1ptr) begin
      enter_state(seq_state_pkg::READ_SRC1_P);
      src1_v = ptr_word(s1n, src1_p);
      check_value("src1_out", src1_v, src1_out);
    end
    // ip wins, then condition
    enter_state(seq_state_pkg::FILL_SRC1);
    if (s1n == 4'(`MM_REG_IP)) begin
      src1_v = exp_ip;
      src1_p = exp_ip;
    end else if (s1n == cn) begin
      src1_v = cond_v;
      src1_p = cond_p;
    end
    check_value("src1_out", src1_v, src1_out);

    enter_state(seq_state_pkg::READ_SRC0);
    src0_v = reg_word(s0n);
    src0_p = src0_v;
    check_value("src0_out", src0_v, src0_out);
    if (s0ptr) begin
      enter_state(seq_state_pkg::READ_SRC0_P);
      src0_v = ptr_word(s0n, src0_p);
      check_value("src0_out", src0_v, src0_out);
    end
    // ip, condition, then source 1
    enter_state(seq_state_pkg::FILL_SRC0);
    if (s0n == 4'(`MM_REG_IP)) begin
      src0_v = exp_ip;
      src0_p = exp_ip;
    end else if (s0n == cn) begin
      src0_v = cond_v;
      src0_p = cond_p;
    end else if (s0n == s1n) begin
      src0_v = src1_v;
      src0_p = src1_p;
    end
    check_value("src0_out", src0_v, src0_out);

    enter_state(seq_state_pkg::READ_DST);
    dst_v = reg_word(dn);
    dst_p = dst_v;
    check_value("dst_out", dst_v, dst_out);
    // alu result replaces the value only
    enter_state(seq_state_pkg::ALU_RESULTS);
    dst_v = dst_in;
    check_value("dst_out", dst_v, dst_out);

    enter_state(seq_state_pkg::WRITE_PREP);
    prep_slot(cptr, cmod, cond_v, cond_p);
    prep_slot(s1ptr, s1mod, src1_v, src1_p);
    prep_slot(s0ptr, s0mod, src0_v, src0_p);
    prep_slot(dptr, dmod, dst_v, dst_p);
    exp_ip = exp_ip + 32'd1;
    check_value("cond_out", cond_v, cond_out);
    check_value("src1_out", src1_v, src1_out);
    check_value("src0_out", src0_v, src0_out);
    check_value("dst_out", dst_v, dst_out);

    wr_before = wr_count;
    enter_state(seq_state_pkg::WRITE_REG_IP);
    check_value("ip write count", 32'(wr_before + 1), 32'(wr_count));
    check_value("ip write address", base_addr_data + `MM_REG_IP, last_wr_addr);
    check_value("ip write data", exp_ip, last_wr_data);

    // destination store goes direct or through its pointer
    wr_before = wr_count;
    if (dptr) begin
      dst_addr = base_addr_data + dst_p;
      enter_state(seq_state_pkg::WRITE_DST_P);
    end else begin
      dst_addr = base_addr_data + 32'(dn);
      enter_state(seq_state_pkg::WRITE_DST);
    end
    check_value("dst write address", dst_addr, last_wr_addr);
    check_value("dst write count", 32'(wr_before + 1), 32'(wr_count));
    check_value("dst write data", dst_v, last_wr_data);
    // a store onto register 15 redirects the next fetch
    if (dst_addr == base_addr_data + `MM_REG_IP) begin
      exp_ip = dst_v;
    end

    @(posedge clk);
    #1;
    state = seq_state_pkg::IDLE;
    repeat (2) @(posedge clk);
    #1;
  endtask

  initial begin
    rst            = 1'b1;
    state          = seq_state_pkg::IDLE;
    base_addr      = '0;
    base_addr_data = '0;
    data_in        = '0;
    read_dn        = 1'b0;
    write_dn       = 1'b0;
    dst_in         = '0;
    errors         = 0;
    hung           = 1'b0;
    run_done       = 1'b0;
    wr_count       = 0;
    last_rd_addr   = '0;
    last_wr_addr   = '0;
    last_wr_data   = '0;
    void'($urandom(32'hf699d545));
    // program and register spaces kept apart
    base_addr      = 32'h0010_0000 | ($urandom & 32'h000f_f000);
    base_addr_data = 32'h0000_4000 + ($urandom & 32'h0000_0ff0);
    exp_ip         = $urandom & 32'h0000_0fff;
    mem[base_addr_data + `MM_REG_IP] = exp_ip;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("read_q", 32'd0, 32'(read_q));
    check_value("write_q", 32'd0, 32'(write_q));
    check_value("next_state", 32'd0, 32'(next_state));
    for (int i = 0; i < N_CMDS; i++) begin
      run_command();
    end
    run_done = 1'b1;
  end

  // end of run, stuck handshake or overall cycle limit
  initial begin
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!run_done && !hung && cycles < RUN_LIMIT);
    if (!run_done && !hung) begin
      errors++;
      $display("Timeout: run did not complete within %0d cycles", RUN_LIMIT);
    end
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
+incdir+verification
hdl/seq_state_pkg.sv
hdl/cmd_word_pkg.sv
hdl/cmd_decode.sv
hdl/ip_fetch.sv
hdl/reg_slot.sv
hdl/operand_forward.sv
hdl/mem_manager.sv
verification/mem_manager_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = mem_manager_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
